// ==== common/dot_pkg.sv ====
`default_nettype none

package dot_pkg;

  //////////////////////////////
  // Lane and word geometry
  //////////////////////////////

  // Multiplier lanes per operand word
  localparam int N_LANES = 4;
  // One signed element
  localparam int LANE_W = 8;
  // Full operand word, four lanes packed
  localparam int WORD_W = N_LANES * LANE_W;
  // Product of two lanes
  localparam int PROD_W = 2 * LANE_W;
  // Adder tree and accumulator width
  localparam int ACC_W = 32;

  //////////////////////////////
  // Vector sizing and timing
  //////////////////////////////

  // Weight words per vector
  localparam int VEC_DEPTH = 16;
  localparam int ADDR_W = 4;
  // Operand latch edge to valid sum at dp_unit out
  localparam int DP_LATENCY = 4;

  // Run control state codes
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_STREAM = 2'd1;
  localparam logic [1:0] ST_DRAIN = 2'd2;

  //////////////////////////////
  // Operand word
  //////////////////////////////

  // Same 32 bits seen two ways
  // Lane 0 sits in the lowest byte
  typedef union packed {
    logic [WORD_W-1:0] raw;
    logic [N_LANES-1:0][LANE_W-1:0] lanes;
  } operand_word_t;

endpackage

`default_nettype wire

// ==== dp_unit/dp_unit.sv ====
`default_nettype none

module dp_unit
  import dot_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  input wire logic enable,
  input wire operand_word_t in_a,
  input wire operand_word_t in_b,
  // Bit 1 latches in_a, bit 0 latches in_b
  input wire logic [1:0] in_valid,
  output logic signed [ACC_W-1:0] out
);

  //////////////////////////////
  // Pipeline registers
  //////////////////////////////

  // Per-lane operand registers
  logic signed [LANE_W-1:0] op_a_q [N_LANES];
  logic signed [LANE_W-1:0] op_b_q [N_LANES];
  // Lane products
  logic signed [PROD_W-1:0] prod_q [N_LANES];
  // First tree level, one sum per lane pair
  logic signed [ACC_W-1:0] pair_q [N_LANES/2];
  // Second tree level
  logic signed [ACC_W-1:0] tree_q;
  // Output register
  logic signed [ACC_W-1:0] out_q;

  assign out = out_q;

  //////////////////////////////
  // Operand latches
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < N_LANES; i++) begin
        op_a_q[i] <= '0;
        op_b_q[i] <= '0;
      end
    end else if (enable) begin
      // Each side loads only on its own strobe
      if (in_valid[1]) begin
        for (int i = 0; i < N_LANES; i++) begin
          op_a_q[i] <= $signed(in_a.lanes[i]);
        end
      end
      if (in_valid[0]) begin
        for (int i = 0; i < N_LANES; i++) begin
          op_b_q[i] <= $signed(in_b.lanes[i]);
        end
      end
    end
  end

  //////////////////////////////
  // Multiply and adder tree
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < N_LANES; i++) begin
        prod_q[i] <= '0;
      end
      for (int i = 0; i < N_LANES / 2; i++) begin
        pair_q[i] <= '0;
      end
      tree_q <= '0;
      out_q <= '0;
    end else if (enable) begin
      // Signed 8x8 products, one per lane
      for (int i = 0; i < N_LANES; i++) begin
        prod_q[i] <= op_a_q[i] * op_b_q[i];
      end
      // Pairwise sums, products sign extended to ACC_W
      for (int i = 0; i < N_LANES / 2; i++) begin
        pair_q[i] <= ACC_W'(prod_q[2*i]) + ACC_W'(prod_q[2*i+1]);
      end
      // Final level of the tree
      tree_q <= pair_q[0] + pair_q[1];
      out_q <= tree_q;
    end
  end

endmodule

`default_nettype wire

// ==== src/weight_buffer.sv ====
`default_nettype none

module weight_buffer
  import dot_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  // Write port, host side
  input wire logic wr_en,
  input wire logic [ADDR_W-1:0] wr_addr,
  input wire operand_word_t wr_data,
  // Read port, run control side
  input wire logic rd_en,
  input wire logic [ADDR_W-1:0] rd_addr,
  output operand_word_t rd_data
);

  //////////////////////////////
  // Storage
  //////////////////////////////

  // One packed weight word per vector position
  operand_word_t mem [VEC_DEPTH];

  // Registered read data
  operand_word_t rd_data_q;

  assign rd_data = rd_data_q;

  // Synchronous write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////
  // Read port
  //////////////////////////////

  // Holds its value between reads
  // Word appears one cycle after rd_en
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_data_q <= '0;
    end else if (rd_en) begin
      rd_data_q <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// ==== src/dot_accumulator.sv ====
`default_nettype none

module dot_accumulator
  import dot_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  // Zero the sum at the start of a run
  input wire logic clear,
  // Tagged pipeline output is valid
  input wire logic add,
  input wire logic signed [ACC_W-1:0] sum_in,
  output logic signed [ACC_W-1:0] acc
);

  //////////////////////////////
  // Running sum
  //////////////////////////////

  logic signed [ACC_W-1:0] acc_q;
  logic signed [ACC_W-1:0] acc_next;

  assign acc = acc_q;

  // Next value of the sum
  // Clear has priority over add
  always_comb begin
    acc_next = acc_q;
    if (clear) begin
      acc_next = '0;
    end else if (add) begin
      // Two's complement wrap, no saturation
      acc_next = acc_q + sum_in;
    end
  end

  //////////////////////////////
  // State
  //////////////////////////////

  // Value holds after done until the next clear
  always_ff @(posedge clk) begin
    if (reset) begin
      acc_q <= '0;
    end else begin
      acc_q <= acc_next;
    end
  end

endmodule

`default_nettype wire

// ==== src/dot_ctrl.sv ====
`default_nettype none

module dot_ctrl
  import dot_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  // Host side
  input wire logic start,
  input wire logic [ADDR_W-1:0] vec_last,
  input wire logic act_valid,
  input wire logic [WORD_W-1:0] act_data,
  input wire logic w_wr,
  output logic busy,
  output logic done,
  // Weight buffer
  output logic buf_wr_en,
  output logic rd_en,
  output logic [ADDR_W-1:0] rd_addr,
  // Dot unit
  output operand_word_t op_a,
  output logic lat_a,
  output logic lat_b,
  output logic dp_enable,
  // Accumulator
  output logic acc_clear,
  output logic acc_add
);

  //////////////////////////////
  // Control state
  //////////////////////////////

  logic [1:0] state_q;
  logic [ADDR_W-1:0] cnt_q;
  logic [ADDR_W-1:0] last_q;
  // Read strobe delayed to line up with rd_data
  logic lat_q;
  // One bit per word inside dp_unit
  logic [DP_LATENCY-1:0] pipe_q;
  logic add_q;
  logic done_q;
  operand_word_t op_a_q;

  logic is_idle;
  logic accept;
  logic finish;

  assign is_idle = (state_q == ST_IDLE);
  // Strobes only count while streaming
  assign accept = act_valid && (state_q == ST_STREAM);
  // Last sum being added, nothing left behind it
  assign finish = (state_q == ST_DRAIN) && add_q && !lat_q && (pipe_q == '0);

  assign busy = !is_idle;
  assign done = done_q;
  // Host writes dropped during a run
  assign buf_wr_en = w_wr && is_idle;
  assign rd_en = accept;
  assign rd_addr = cnt_q;
  assign op_a = op_a_q;
  assign lat_a = lat_q;
  assign lat_b = lat_q;
  assign dp_enable = busy;
  assign acc_clear = start && is_idle;
  assign acc_add = add_q;

  //////////////////////////////
  // Idle / stream / drain FSM
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= ST_IDLE;
      cnt_q <= '0;
      last_q <= '0;
      done_q <= 1'b0;
    end else begin
      done_q <= finish;
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            state_q <= ST_STREAM;
            cnt_q <= '0;
            last_q <= vec_last;
          end
        end
        ST_STREAM: begin
          if (accept) begin
            cnt_q <= cnt_q + 1'b1;
            // Final word issued, wait for the pipe
            if (cnt_q == last_q) begin
              state_q <= ST_DRAIN;
            end
          end
        end
        ST_DRAIN: begin
          if (finish) begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  //////////////////////////////
  // Operand and tag pipe
  //////////////////////////////

  // Activation captured alongside the weight read
  always_ff @(posedge clk) begin
    if (accept) begin
      op_a_q.raw <= act_data;
    end
  end

  // Tag follows each word through dp_unit
  always_ff @(posedge clk) begin
    if (reset) begin
      lat_q <= 1'b0;
      pipe_q <= '0;
      add_q <= 1'b0;
    end else begin
      lat_q <= accept;
      pipe_q <= {pipe_q[DP_LATENCY-2:0], lat_q};
      add_q <= pipe_q[DP_LATENCY-1];
    end
  end

endmodule

`default_nettype wire

// ==== src/dot_engine_top.sv ====
`default_nettype none

module dot_engine_top
  import dot_pkg::*;
(
  input wire logic clk,
  input wire logic reset,
  // Weight load
  input wire logic w_wr,
  input wire logic [ADDR_W-1:0] w_addr,
  input wire logic [WORD_W-1:0] w_data,
  // Run control
  input wire logic start,
  input wire logic [ADDR_W-1:0] vec_last,
  input wire logic act_valid,
  input wire logic [WORD_W-1:0] act_data,
  output logic busy,
  output logic done,
  output logic signed [ACC_W-1:0] result
);

  //////////////////////////////
  // Internal nets
  //////////////////////////////

  logic buf_wr_en;
  logic rd_en;
  logic [ADDR_W-1:0] rd_addr;
  operand_word_t rd_data;
  operand_word_t op_a;
  operand_word_t wr_word;
  logic lat_a;
  logic lat_b;
  logic dp_enable;
  logic acc_clear;
  logic acc_add;
  logic signed [ACC_W-1:0] dp_out;

  assign wr_word.raw = w_data;

  dot_ctrl dot_ctrl_i (
    .clk, .reset, .start, .vec_last, .act_valid, .act_data, .w_wr,
    .busy, .done, .buf_wr_en, .rd_en, .rd_addr, .op_a,
    .lat_a, .lat_b, .dp_enable, .acc_clear, .acc_add
  );

  weight_buffer weight_buffer_i (
    .clk, .reset, .wr_en(buf_wr_en), .wr_addr(w_addr), .wr_data(wr_word),
    .rd_en, .rd_addr, .rd_data
  );

  // Weight word goes straight from the buffer to operand b
  dp_unit dp_unit_i (
    .clk, .reset, .enable(dp_enable), .in_a(op_a), .in_b(rd_data),
    .in_valid({lat_a, lat_b}), .out(dp_out)
  );

  dot_accumulator dot_accumulator_i (
    .clk, .reset, .clear(acc_clear), .add(acc_add), .sum_in(dp_out), .acc(result)
  );

endmodule

`default_nettype wire

// ==== tb/clk_gen.sv ====
`default_nettype none

module clk_gen (
  output logic clk,
  output logic reset
);

  // 40 unit period, reset over two rising edges
  localparam int PERIOD = 40;
  localparam int RESET_CYCLES = 2;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Release on a falling edge, like all other stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb/dot_engine_tb.sv ====
`default_nettype none

module dot_engine_tb
  import dot_pkg::*;
();

  // About ten 16-word runs with gaps and loads fit well inside this
  localparam int MAX_CYCLES = 2000;
  // Edge sampling the last act_valid to done seen high
  localparam int DONE_DELAY = 6;

  logic clk;
  logic reset;
  logic w_wr;
  logic [ADDR_W-1:0] w_addr;
  logic [WORD_W-1:0] w_data;
  logic start;
  logic [ADDR_W-1:0] vec_last;
  logic act_valid;
  logic [WORD_W-1:0] act_data;
  logic busy;
  logic done;
  logic signed [ACC_W-1:0] result;

  // Model state
  operand_word_t wts [VEC_DEPTH];
  operand_word_t acts [VEC_DEPTH];
  logic signed [ACC_W-1:0] exp_result;
  logic check_result;
  // Marks the final word of a run on the act strobe
  logic act_last;
  logic [DONE_DELAY:0] last_pipe;
  int mismatches;
  int failures;
  int cycles;
  int seed;
  int n;

  clk_gen clk_gen_i (.clk, .reset);

  dot_engine_top dot_engine_top_i (
    .clk, .reset, .w_wr, .w_addr, .w_data, .start, .vec_last,
    .act_valid, .act_data, .busy, .done, .result
  );

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Signed lane products summed in 32 bits
  function automatic logic signed [ACC_W-1:0] word_dot(operand_word_t w, operand_word_t a);
    logic signed [ACC_W-1:0] sum;
    logic signed [ACC_W-1:0] wl;
    logic signed [ACC_W-1:0] al;
    sum = '0;
    for (int i = 0; i < N_LANES; i++) begin
      wl = $signed(w.lanes[i]);
      al = $signed(a.lanes[i]);
      sum = sum + wl * al;
    end
    return sum;
  endfunction

  // Expected done slot, shifted from the last accepted strobe
  always_ff @(posedge clk) begin
    if (reset) begin
      last_pipe <= '0;
    end else begin
      last_pipe <= {last_pipe[DONE_DELAY-1:0], act_valid && act_last};
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  assert property (@(posedge clk) disable iff (reset) done == last_pipe[DONE_DELAY])
    else begin
      mismatches++;
      $display("MISMATCH at %0t: done is %0b, expected %0b", $time,
               $sampled(done), $sampled(last_pipe[DONE_DELAY]));
    end

  assert property (@(posedge clk) disable iff (reset)
                   done && check_result |-> result == exp_result)
    else begin
      mismatches++;
      $display("MISMATCH at %0t: result %0d, expected %0d", $time,
               $sampled(result), $sampled(exp_result));
    end

  // Zero right after an accepted start
  assert property (@(posedge clk) disable iff (reset) start && !busy |=> result == '0)
    else begin
      mismatches++;
      $display("MISMATCH at %0t: result %0d not cleared by start", $time, $sampled(result));
    end

  // Held from done until the next start
  assert property (@(posedge clk) disable iff (reset)
                   !busy && !start |=> result === $past(result))
    else begin
      mismatches++;
      $display("MISMATCH at %0t: result changed while idle", $time);
    end

  assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
      failures++;
      $display("done stayed high for more than one cycle at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (reset) start && !busy |=> busy)
    else begin
      failures++;
      $display("busy did not rise after start at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (reset) $fell(busy) |-> done)
    else begin
      failures++;
      $display("busy dropped without a done pulse at %0t", $time);
    end

  assert property (@(posedge clk) disable iff (reset) $rose(busy) |-> $past(start))
    else begin
      failures++;
      $display("busy rose without a start at %0t", $time);
    end

  //////////////////////////////
  // Watchdog
  //////////////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, %0d mismatches, %0d other errors",
               MAX_CYCLES, mismatches, failures);
      $display("Simulation failed");
      $finish;
    end
  end

  //////////////////////////////
  // Stimulus tasks
  //////////////////////////////

  // All tasks start and end on a falling edge
  task automatic write_weight(input int addr, input operand_word_t data);
    w_wr = 1'b1;
    w_addr = addr[ADDR_W-1:0];
    w_data = data.raw;
    @(negedge clk);
    w_wr = 1'b0;
  endtask

  task automatic load_weights();
    for (int i = 0; i < VEC_DEPTH; i++) begin
      write_weight(i, wts[i]);
    end
  endtask

  task automatic randomize_vectors();
    for (int i = 0; i < VEC_DEPTH; i++) begin
      wts[i].raw = $urandom();
      acts[i].raw = $urandom();
    end
  endtask

  // Act strobes with nothing running
  task automatic stray_strobes(input int count);
    act_valid = 1'b1;
    act_data = $urandom();
    repeat (count) @(negedge clk);
    act_valid = 1'b0;
  endtask

  // Interfering writes, start and extra strobes go in while busy
  task automatic run_vector(input int len, input int max_gap, input bit check,
                            input bit interfere);
    int gap;
    logic signed [ACC_W-1:0] sum;
    sum = '0;
    for (int i = 0; i < len; i++) begin
      sum = sum + word_dot(wts[i], acts[i]);
    end
    exp_result = sum;
    check_result = check;
    start = 1'b1;
    vec_last = ADDR_W'(len - 1);
    @(negedge clk);
    start = 1'b0;
    for (int i = 0; i < len; i++) begin
      gap = $urandom_range(max_gap, 0);
      repeat (gap) @(negedge clk);
      act_valid = 1'b1;
      act_data = acts[i].raw;
      act_last = (i == len - 1);
      if (interfere && i == 1) begin
        // Target a weight not read yet
        w_wr = 1'b1;
        w_addr = ADDR_W'(len - 1);
        w_data = $urandom();
        start = 1'b1;
        vec_last = '0;
      end
      @(negedge clk);
      act_valid = 1'b0;
      act_last = 1'b0;
      w_wr = 1'b0;
      start = 1'b0;
    end
    if (interfere) begin
      stray_strobes(3);
    end
    while (done !== 1'b1) @(negedge clk);
    @(negedge clk);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    seed = $urandom(32'h6c08);
    w_wr = 1'b0;
    w_addr = '0;
    w_data = '0;
    start = 1'b0;
    vec_last = '0;
    act_valid = 1'b0;
    act_data = '0;
    act_last = 1'b0;
    check_result = 1'b0;
    exp_result = '0;
    mismatches = 0;
    failures = 0;
    cycles = 0;
    @(negedge clk);
    while (reset) @(negedge clk);
    assert (busy === 1'b0 && done === 1'b0 && result === '0)
      else begin
        mismatches++;
        $display("MISMATCH at %0t: outputs not cleared by reset", $time);
      end
    // Empty store, only the cleared sum and the timing are checked
    randomize_vectors();
    run_vector(4, 0, 1'b0, 1'b0);
    // Full vector, back to back
    randomize_vectors();
    load_weights();
    run_vector(VEC_DEPTH, 0, 1'b1, 1'b0);
    // Random lengths with gaps
    repeat (6) begin
      randomize_vectors();
      load_weights();
      n = $urandom_range(VEC_DEPTH, 1);
      run_vector(n, 3, 1'b1, 1'b0);
      repeat ($urandom_range(4, 0)) @(negedge clk);
    end
    // -128 in every lane
    for (int i = 0; i < VEC_DEPTH; i++) begin
      wts[i].raw = {N_LANES{8'h80}};
      acts[i].raw = {N_LANES{8'h80}};
    end
    load_weights();
    run_vector(VEC_DEPTH, 0, 1'b1, 1'b0);
    // Ignored idle strobes, then a run with interference
    randomize_vectors();
    load_weights();
    stray_strobes(2);
    run_vector(VEC_DEPTH, 2, 1'b1, 1'b1);
    // Rewritten weight counts in the next run
    wts[VEC_DEPTH-1].raw = $urandom();
    write_weight(VEC_DEPTH - 1, wts[VEC_DEPTH-1]);
    run_vector(VEC_DEPTH, 1, 1'b1, 1'b0);
    repeat (4) @(negedge clk);
    $display("Checks complete: %0d mismatches, %0d other errors", mismatches, failures);
    if (mismatches + failures == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
common/dot_pkg.sv
dp_unit/dp_unit.sv
src/weight_buffer.sv
src/dot_accumulator.sv
src/dot_ctrl.sv
src/dot_engine_top.sv
tb/clk_gen.sv
tb/dot_engine_tb.sv

// ==== Bender.yml ====
package:
  name: dot_engine

sources:
  # Shared package first
  - files:
      - common/dot_pkg.sv
  # Datapath, control and top level
  - files:
      - dp_unit/dp_unit.sv
      - src/weight_buffer.sv
      - src/dot_accumulator.sv
      - src/dot_ctrl.sv
      - src/dot_engine_top.sv
  # Testbench
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/dot_engine_tb.sv
